//--- rtl/mc_xbar_cord_pkg.sv
package mc_xbar_cord_pkg;

  // coordinate field widths.
  localparam int x_cord_width_c = 3;
  localparam int y_cord_width_c = 3;

  // y sits in the upper bits of the coordinate word.
  typedef struct packed {
    logic [y_cord_width_c-1:0] y;
    logic [x_cord_width_c-1:0] x;
  } cord_s;

  // tile array size.
  localparam int num_tiles_x_c = 2;
  localparam int num_tiles_y_c = 2;

  // host position.
  localparam int host_x_cord_c = 0;
  localparam int host_y_cord_c = 0;

  // host, tiles, then the north and south vcache rows.
  localparam int num_out_c = 1 + (num_tiles_x_c * num_tiles_y_c) + (2 * num_tiles_x_c);

endpackage

//--- rtl/mc_xbar_packet_pkg.sv
package mc_xbar_packet_pkg;

  localparam int data_width_c = 16;

  // number of source ports feeding the crossbar.
  localparam int num_src_c = 2;

  // single flit network packet.
  typedef struct packed {
    mc_xbar_cord_pkg::cord_s cord;
    logic [data_width_c-1:0] data;
  } packet_s;

endpackage

//--- rtl/mc_xbar_route_if.sv
interface mc_xbar_route_if;

  import mc_xbar_cord_pkg::*;
  import mc_xbar_packet_pkg::*;

  // plain strobe, no handshake.
  logic valid;
  packet_s pkt;

  // one-hot output select, all zero for an unmapped coordinate.
  logic [num_out_c-1:0] sel;

  modport dec (
    output valid,
    output pkt,
    output sel
  );

  modport arb (
    input valid,
    input pkt,
    input sel
  );

endinterface

//--- rtl/mc_xbar_cord_decode.sv
module mc_xbar_cord_decode #(
  parameter int num_tiles_x_p = 2,
  parameter int num_tiles_y_p = 2,
  parameter int host_x_cord_p = 0,
  parameter int host_y_cord_p = 0,
  parameter bit fwd_not_rev_p = 1'b1
) (
  input  logic                        clk_i,
  input  logic                        reset,
  input  logic                        valid,
  input  mc_xbar_packet_pkg::packet_s pkt,
  mc_xbar_route_if.dec                route
);

  import mc_xbar_cord_pkg::*;

  localparam int tile_base_lp  = 1;
  localparam int north_base_lp = tile_base_lp + (num_tiles_x_p * num_tiles_y_p);
  localparam int south_base_lp = north_base_lp + num_tiles_x_p;

  logic [y_cord_width_c-1:0] y_cord;
  logic [x_cord_width_c-1:0] x_cord;
  logic [y_cord_width_c-1:0] tile_y;
  logic [x_cord_width_c-1:0] tile_x;
  logic                      host_hit;
  logic                      x_in_array;
  logic                      tile_hit;
  logic                      north_hit;
  logic                      south_hit;
  logic [num_out_c-1:0]      sel_next;

  assign y_cord = pkt.cord.y;
  assign x_cord = pkt.cord.x;

  // offsets into the tile array, also used for the vcache rows.
  assign tile_y = y_cord - y_cord_width_c'(num_tiles_y_p);
  assign tile_x = x_cord - x_cord_width_c'(num_tiles_x_p);

  assign host_hit = (y_cord == y_cord_width_c'(host_y_cord_p))
                 && (x_cord == x_cord_width_c'(host_x_cord_p));

  assign x_in_array = (x_cord >= x_cord_width_c'(num_tiles_x_p))
                   && (x_cord < x_cord_width_c'(2 * num_tiles_x_p));

  assign tile_hit = x_in_array
                 && (y_cord >= y_cord_width_c'(num_tiles_y_p))
                 && (y_cord < y_cord_width_c'(2 * num_tiles_y_p));

  // vcache rows exist on the forward network only.
  assign north_hit = fwd_not_rev_p && x_in_array
                  && (y_cord == y_cord_width_c'(num_tiles_y_p - 1));
  assign south_hit = fwd_not_rev_p && x_in_array
                  && (y_cord == y_cord_width_c'(2 * num_tiles_y_p));

  always_comb begin
    sel_next = '0;
    sel_next[0] = host_hit;
    for (int ty = 0; ty < num_tiles_y_p; ty++) begin
      for (int tx = 0; tx < num_tiles_x_p; tx++) begin
        sel_next[tile_base_lp + (ty * num_tiles_x_p) + tx] = tile_hit
          && (tile_y == y_cord_width_c'(ty)) && (tile_x == x_cord_width_c'(tx));
      end
    end
    if (fwd_not_rev_p) begin
      for (int tx = 0; tx < num_tiles_x_p; tx++) begin
        sel_next[north_base_lp + tx] = north_hit && (tile_x == x_cord_width_c'(tx));
        sel_next[south_base_lp + tx] = south_hit && (tile_x == x_cord_width_c'(tx));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      route.valid <= 1'b0;
    end else begin
      route.valid <= valid;
    end
  end

  always_ff @(posedge clk_i) begin
    route.pkt <= pkt;
    route.sel <= sel_next;
  end

endmodule

//--- rtl/mc_xbar_rr_arbiter.sv
module mc_xbar_rr_arbiter #(
  parameter int num_out_p = 9
) (
  input  logic                                      clk_i,
  input  logic                                      reset,
  mc_xbar_route_if.arb                              route_0,
  mc_xbar_route_if.arb                              route_1,
  output logic [num_out_p-1:0]                      grant_valid,
  output logic [num_out_p-1:0]                      grant_src,
  output logic [mc_xbar_packet_pkg::num_src_c-1:0] lose,
  output logic [mc_xbar_packet_pkg::num_src_c-1:0] unmapped,
  output mc_xbar_packet_pkg::packet_s               pkt_0,
  output mc_xbar_packet_pkg::packet_s               pkt_1
);

  logic [num_out_p-1:0] req_0;
  logic [num_out_p-1:0] req_1;

  // preferred source per output.
  logic [num_out_p-1:0] ptr_r;
  logic [num_out_p-1:0] ptr_next;

  // a source requests the output named by its select.
  assign req_0 = {num_out_p{route_0.valid}} & route_0.sel[num_out_p-1:0];
  assign req_1 = {num_out_p{route_1.valid}} & route_1.sel[num_out_p-1:0];

  always_comb begin
    for (int o = 0; o < num_out_p; o++) begin
      grant_valid[o] = req_0[o] | req_1[o];
      if (req_0[o] && req_1[o]) begin
        grant_src[o] = ptr_r[o];
      end else begin
        grant_src[o] = req_1[o];
      end
      // the winner gives up priority, an idle output holds.
      if (grant_valid[o]) begin
        ptr_next[o] = ~grant_src[o];
      end else begin
        ptr_next[o] = ptr_r[o];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      ptr_r <= '0;
    end else begin
      ptr_r <= ptr_next;
    end
  end

  // each select is one-hot, so a source loses on at most one output.
  assign lose[0] = |(req_0 & grant_src);
  assign lose[1] = |(req_1 & ~grant_src);

  // valid with no select bit set means no output owns the coordinate.
  assign unmapped[0] = route_0.valid && (route_0.sel == '0);
  assign unmapped[1] = route_1.valid && (route_1.sel == '0);

  assign pkt_0 = route_0.pkt;
  assign pkt_1 = route_1.pkt;

endmodule

//--- rtl/mc_xbar_deliver.sv
module mc_xbar_deliver #(
  parameter int num_out_p = 9
) (
  input  logic                                                      clk_i,
  input  logic                                                      reset,
  input  logic [num_out_p-1:0]                                      grant_valid,
  input  logic [num_out_p-1:0]                                      grant_src,
  input  logic [mc_xbar_packet_pkg::num_src_c-1:0]                 lose,
  input  logic [mc_xbar_packet_pkg::num_src_c-1:0]                 unmapped,
  input  mc_xbar_packet_pkg::packet_s                               pkt_0,
  input  mc_xbar_packet_pkg::packet_s                               pkt_1,
  output logic [num_out_p-1:0]                                      out_valid,
  output logic [num_out_p-1:0][mc_xbar_packet_pkg::data_width_c-1:0] out_data,
  output logic [mc_xbar_packet_pkg::num_src_c-1:0]                 drop_lost,
  output logic [mc_xbar_packet_pkg::num_src_c-1:0]                 drop_unmapped
);

  // strobes and drop pulses.
  always_ff @(posedge clk_i) begin
    if (reset) begin
      out_valid     <= '0;
      drop_lost     <= '0;
      drop_unmapped <= '0;
    end else begin
      out_valid     <= grant_valid;
      drop_lost     <= lose;
      drop_unmapped <= unmapped;
    end
  end

  // data follows the winning source, idle outputs keep their last word.
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < num_out_p; o++) begin
      if (grant_valid[o]) begin
        out_data[o] <= grant_src[o] ? pkt_1.data : pkt_0.data;
      end
    end
  end

endmodule

//--- rtl/mc_xbar_top.sv
module mc_xbar_top (
  input  logic clk_i,
  input  logic reset,
  input  logic [mc_xbar_packet_pkg::num_src_c-1:0] in_valid,
  input  logic [mc_xbar_packet_pkg::num_src_c-1:0]
               [mc_xbar_cord_pkg::y_cord_width_c+mc_xbar_cord_pkg::x_cord_width_c-1:0] in_cord,
  input  logic [mc_xbar_packet_pkg::num_src_c-1:0]
               [mc_xbar_packet_pkg::data_width_c-1:0] in_data,
  output logic [mc_xbar_cord_pkg::num_out_c-1:0] out_valid,
  output logic [mc_xbar_cord_pkg::num_out_c-1:0]
               [mc_xbar_packet_pkg::data_width_c-1:0] out_data,
  output logic [mc_xbar_packet_pkg::num_src_c-1:0] drop_lost,
  output logic [mc_xbar_packet_pkg::num_src_c-1:0] drop_unmapped
);

  import mc_xbar_cord_pkg::*;
  import mc_xbar_packet_pkg::*;

  packet_s              in_pkt_0;
  packet_s              in_pkt_1;
  packet_s              arb_pkt_0;
  packet_s              arb_pkt_1;
  logic [num_out_c-1:0] grant_valid;
  logic [num_out_c-1:0] grant_src;
  logic [num_src_c-1:0] lose;
  logic [num_src_c-1:0] unmapped;

  assign in_pkt_0 = {in_cord[0], in_data[0]};
  assign in_pkt_1 = {in_cord[1], in_data[1]};

  mc_xbar_route_if route_0 ();
  mc_xbar_route_if route_1 ();

  mc_xbar_cord_decode #(
    .num_tiles_x_p(num_tiles_x_c),
    .num_tiles_y_p(num_tiles_y_c),
    .host_x_cord_p(host_x_cord_c),
    .host_y_cord_p(host_y_cord_c),
    .fwd_not_rev_p(1'b1)
  ) decode_0 (
    .clk_i(clk_i),
    .reset(reset),
    .valid(in_valid[0]),
    .pkt  (in_pkt_0),
    .route(route_0)
  );

  mc_xbar_cord_decode #(
    .num_tiles_x_p(num_tiles_x_c),
    .num_tiles_y_p(num_tiles_y_c),
    .host_x_cord_p(host_x_cord_c),
    .host_y_cord_p(host_y_cord_c),
    .fwd_not_rev_p(1'b1)
  ) decode_1 (
    .clk_i(clk_i),
    .reset(reset),
    .valid(in_valid[1]),
    .pkt  (in_pkt_1),
    .route(route_1)
  );

  mc_xbar_rr_arbiter #(
    .num_out_p(num_out_c)
  ) arbiter (
    .clk_i      (clk_i),
    .reset      (reset),
    .route_0    (route_0),
    .route_1    (route_1),
    .grant_valid(grant_valid),
    .grant_src  (grant_src),
    .lose       (lose),
    .unmapped   (unmapped),
    .pkt_0      (arb_pkt_0),
    .pkt_1      (arb_pkt_1)
  );

  mc_xbar_deliver #(
    .num_out_p(num_out_c)
  ) deliver (
    .clk_i        (clk_i),
    .reset        (reset),
    .grant_valid  (grant_valid),
    .grant_src    (grant_src),
    .lose         (lose),
    .unmapped     (unmapped),
    .pkt_0        (arb_pkt_0),
    .pkt_1        (arb_pkt_1),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .drop_lost    (drop_lost),
    .drop_unmapped(drop_unmapped)
  );

endmodule

//--- bench/mc_xbar_sva.sv
module mc_xbar_sva #(
  parameter int num_out_p = 9
) (
  input logic                                      clk_i,
  input logic                                      reset,
  input logic [num_out_p-1:0]                      grant_src,
  input logic [num_out_p-1:0]                      out_valid,
  input logic [mc_xbar_packet_pkg::num_src_c-1:0] drop_lost,
  input logic [mc_xbar_packet_pkg::num_src_c-1:0] drop_unmapped
);

  idle_after_reset: assert property (@(posedge clk_i) reset |=> out_valid == '0)
    else $error("out_valid set in the cycle after reset");

  // a packet is either lost or unmapped, never both.
  one_drop_kind: assert property (@(posedge clk_i) disable iff (reset)
    (drop_lost & drop_unmapped) == '0)
    else $error("drop_lost and drop_unmapped high for the same source");

  // the loser's rival must have been delivered.
  lost_0_has_winner: assert property (@(posedge clk_i) disable iff (reset)
    drop_lost[0] |-> |(out_valid & $past(grant_src)))
    else $error("source 0 dropped with no delivery from source 1");

  lost_1_has_winner: assert property (@(posedge clk_i) disable iff (reset)
    drop_lost[1] |-> |(out_valid & ~$past(grant_src)))
    else $error("source 1 dropped with no delivery from source 0");

endmodule

bind mc_xbar_deliver mc_xbar_sva #(
  .num_out_p(num_out_p)
) sva (
  .clk_i        (clk_i),
  .reset        (reset),
  .grant_src    (grant_src),
  .out_valid    (out_valid),
  .drop_lost    (drop_lost),
  .drop_unmapped(drop_unmapped)
);

//--- bench/mc_xbar_tb.sv
module mc_xbar_tb;

  import mc_xbar_cord_pkg::*;
  import mc_xbar_packet_pkg::*;

  localparam int cord_width_lp = y_cord_width_c + x_cord_width_c;

  typedef struct packed {
    logic [num_out_c-1:0]                   valid;
    logic [num_out_c-1:0][data_width_c-1:0] data;
    logic [num_src_c-1:0]                   lost;
    logic [num_src_c-1:0]                   unmapped;
    logic                                   active;
  } pred_s;

  logic                                    clk_i;
  logic                                    reset;
  logic [num_src_c-1:0]                    in_valid;
  logic [num_src_c-1:0][cord_width_lp-1:0] in_cord;
  logic [num_src_c-1:0][data_width_c-1:0]  in_data;
  logic [num_out_c-1:0]                    out_valid;
  logic [num_out_c-1:0][data_width_c-1:0]  out_data;
  logic [num_src_c-1:0]                    drop_lost;
  logic [num_src_c-1:0]                    drop_unmapped;

  pred_s                pred_q[$];
  logic [num_out_c-1:0] ptr_model;
  int                   pushed = 0;
  int                   checked = 0;

  mc_xbar_top dut (
    .clk_i        (clk_i),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_cord      (in_cord),
    .in_data      (in_data),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .drop_lost    (drop_lost),
    .drop_unmapped(drop_unmapped)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // output index for a coordinate, -1 when nothing owns it.
  function automatic int cord_to_out(input logic [cord_width_lp-1:0] cord);
    int y;
    int x;
    int idx;
    y = int'(cord[cord_width_lp-1:x_cord_width_c]);
    x = int'(cord[x_cord_width_c-1:0]);
    idx = -1;
    if (y == host_y_cord_c && x == host_x_cord_c) begin
      idx = 0;
    end else if (x >= num_tiles_x_c && x < 2 * num_tiles_x_c) begin
      if (y >= num_tiles_y_c && y < 2 * num_tiles_y_c) begin
        idx = 1 + (y - num_tiles_y_c) * num_tiles_x_c + (x - num_tiles_x_c);
      end else if (y == num_tiles_y_c - 1) begin
        idx = 5 + x - num_tiles_x_c;
      end else if (y == 2 * num_tiles_y_c) begin
        idx = 7 + x - num_tiles_x_c;
      end
    end
    return idx;
  endfunction

  // mostly near the array, sometimes anywhere.
  function automatic logic [cord_width_lp-1:0] rand_cord();
    logic [2:0] y;
    logic [2:0] x;
    if ($urandom_range(3) == 0) begin
      return cord_width_lp'($urandom);
    end
    y = 3'($urandom_range(4));
    x = 3'($urandom_range(4));
    return {y, x};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, name, got, want);
      $display(">>> FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic drive_pair(input logic [1:0] valid, input logic [5:0] cord_0,
                            input logic [5:0] cord_1);
    @(negedge clk_i);
    in_valid   = valid;
    in_cord[0] = cord_0;
    in_cord[1] = cord_1;
    in_data[0] = 16'($urandom);
    in_data[1] = 16'($urandom);
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (checked != pushed) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 20) begin
        $display("timeout: %0d packet cycles never reached the outputs", pushed - checked);
        $display(">>> FAIL");
        $fatal(1, "drain timeout");
      end
    end
  endtask

  // reference model of the round-robin pointers.
  always @(posedge clk_i) begin : model
    pred_s p;
    int    d0;
    int    d1;
    logic  win;
    p = '0;
    if (reset) begin
      ptr_model = '0;
    end else begin
      d0 = in_valid[0] ? cord_to_out(in_cord[0]) : -2;
      d1 = in_valid[1] ? cord_to_out(in_cord[1]) : -2;
      p.unmapped = {d1 == -1, d0 == -1};
      if (d0 >= 0 && d0 == d1) begin
        win = ptr_model[d0];
        p.lost = win ? 2'b01 : 2'b10;
        p.valid[d0] = 1'b1;
        p.data[d0] = win ? in_data[1] : in_data[0];
        ptr_model[d0] = ~win;
      end else begin
        if (d0 >= 0) begin
          p.valid[d0] = 1'b1;
          p.data[d0] = in_data[0];
          ptr_model[d0] = 1'b1;
        end
        if (d1 >= 0) begin
          p.valid[d1] = 1'b1;
          p.data[d1] = in_data[1];
          ptr_model[d1] = 1'b0;
        end
      end
      p.active = |in_valid;
    end
    if (p.active) begin
      pushed++;
    end
    pred_q.push_back(p);
  end

  // outputs settle after the rising edge, so compare on the falling one.
  always @(negedge clk_i) begin : compare
    pred_s p;
    if (pred_q.size() >= 2) begin
      p = pred_q.pop_front();
      check_value("out_valid", 32'(out_valid), 32'(p.valid));
      check_value("drop_lost", 32'(drop_lost), 32'(p.lost));
      check_value("drop_unmapped", 32'(drop_unmapped), 32'(p.unmapped));
      for (int o = 0; o < num_out_c; o++) begin
        if (p.valid[o]) begin
          check_value($sformatf("out_data[%0d]", o), 32'(out_data[o]), 32'(p.data[o]));
        end
      end
      if (p.active) begin
        checked++;
      end
    end
  end

  initial begin
    void'($urandom(32'h56a27640));
    in_valid = '0;
    in_cord  = '0;
    in_data  = '0;
    reset    = 1'b1;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset = 1'b0;
    repeat (4) drive_pair(2'b00, 6'd0, 6'd0);
    // every coordinate once from each source, one packet per cycle.
    for (int c = 0; c < 128; c++) begin
      drive_pair(c[6] ? 2'b10 : 2'b01, 6'(c), 6'(c));
    end
    // both sources on one tile, then on the host.
    repeat (6) drive_pair(2'b11, {3'd2, 3'd3}, {3'd2, 3'd3});
    repeat (6) drive_pair(2'b11, 6'd0, 6'd0);
    for (int i = 0; i < 4000; i++) begin
      drive_pair(2'($urandom), rand_cord(), rand_cord());
    end
    drive_pair(2'b00, 6'd0, 6'd0);
    wait_drained();
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- mc_xbar.f
rtl/mc_xbar_cord_pkg.sv
rtl/mc_xbar_packet_pkg.sv
rtl/mc_xbar_route_if.sv
rtl/mc_xbar_cord_decode.sv
rtl/mc_xbar_rr_arbiter.sv
rtl/mc_xbar_deliver.sv
rtl/mc_xbar_top.sv
bench/mc_xbar_sva.sv
bench/mc_xbar_tb.sv

//--- run_mc_xbar.sh
#!/bin/sh
# build and run the crossbar testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mc_xbar.f --top-module mc_xbar_tb -o mc_xbar_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/mc_xbar_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx -- '>>> PASS'; then
  exit 0
fi
echo "pass message not found"
exit 1
